//--- files.f
+incdir+src
src/aes_pkg.sv
src/aes_sbox.sv
src/aes_round.sv
src/aes_key_sched.sv
src/aes_ctrl.sv
src/aes_core.sv
tb/aes_assert.sv
tb/aes_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the AES-128 core and its testbench with Verilator, run it, and scan the log.
set -e
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert --top-module aes_tb -f files.f -o aes_sim

# The error limit lets the run reach its own summary after an assertion fires.
if ! ./obj_dir/aes_sim +verilator+error+limit+1000 > "$log" 2>&1; then
	echo "simulator returned an error status"
fi
cat "$log"

if grep -q "SIMULATION FAILED" "$log"; then
	echo "run failed, see $log"
	exit 1
fi
if ! grep -q "SIMULATION PASSED" "$log"; then
	echo "run ended without a result, see $log"
	exit 1
fi
echo "run passed"

//--- src/aes_config.svh
// Build-time constants for the AES-128 encryption core.
// Round count, block and key width, and the GF(2^8) reduction constant.

`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// ----------------------------------------
// cipher geometry
// ----------------------------------------

// number of cipher rounds for a 128-bit key.
`define AES_ROUNDS 10

// width of one state block, and of the cipher key.
`define AES_BLOCK_BITS 128

// low byte of the field polynomial x^8 + x^4 + x^3 + x + 1, xored in when doubling overflows.
`define AES_GF_POLY 8'h1b

`endif

//--- src/aes_core.sv
// Top level of the iterative AES-128 encryption core.
// Cipher state register, ciphertext register, and the control FSM,
// key schedule and round datapath instances.

`timescale 1ns/10ps

module aes_core import aes_pkg::*; (
	input  logic       eph1,
	input  logic       rst_n,
	input  logic       start,
	input  aes_block_t key,
	input  aes_block_t plain_text,
	output logic       busy,
	output logic       done,
	output aes_block_t cipher_text
);

	logic       load;
	logic       final_round;
	aes_block_t state_q;
	aes_block_t round_key;
	aes_block_t next_state;
	aes_block_t cipher_q;

	// ----------------------------------------
	// sequencing and key expansion
	// ----------------------------------------

	aes_ctrl aes_ctrl_inst (
		.eph1        (eph1),
		.rst_n       (rst_n),
		.start       (start),
		.load        (load),
		.busy        (busy),
		.final_round (final_round),
		.done        (done)
	);

	// the schedule advances on every round edge, in step with the state.
	aes_key_sched aes_key_sched_inst (
		.eph1       (eph1),
		.rst_n      (rst_n),
		.load       (load),
		.step       (busy),
		.cipher_key (key),
		.round_key  (round_key)
	);

	aes_round aes_round_inst (
		.state       (state_q),
		.round_key   (round_key),
		.final_round (final_round),
		.next_state  (next_state)
	);

	// ----------------------------------------
	// state and ciphertext registers
	// ----------------------------------------

	// load applies the initial AddRoundKey with the cipher key itself.
	// after that each busy edge takes one round result.
	always_ff @(posedge eph1) begin
		if (load) begin
			state_q <= plain_text ^ key;
		end else if (busy) begin
			state_q <= next_state;
		end
	end

	// the result is caught at the end of round 10 and held until the next block finishes.
	always_ff @(posedge eph1 or negedge rst_n) begin
		if (!rst_n) begin
			cipher_q <= '0;
		end else if (final_round) begin
			cipher_q <= next_state;
		end
	end

	assign cipher_text = cipher_q;

endmodule

//--- src/aes_ctrl.sv
// Control FSM of the iterative AES core.
// Idle/run state, round counter, and the load, busy, final-round and
// done strobes that sequence the datapath.

`timescale 1ns/10ps

`include "aes_config.svh"

module aes_ctrl import aes_pkg::*; (
	input  logic eph1,
	input  logic rst_n,
	input  logic start,
	output logic load,
	output logic busy,
	output logic final_round,
	output logic done
);

	// number of the last round, in the width of the counter.
	localparam round_idx_t LAST_ROUND = round_idx_t'(`AES_ROUNDS);

	ctrl_state_t state_q;
	round_idx_t  round_q;
	logic        done_q;

	// ----------------------------------------
	// decoded strobes
	// ----------------------------------------

	// a start is taken only when no block is in flight, and the idle
	// cycle that carries done counts as one.
	assign load = (state_q == CTRL_IDLE) && start;

	// busy covers exactly the ten round cycles.
	assign busy = (state_q == CTRL_RUN);

	// the round datapath uses this to drop MixColumns, and the core uses
	// it to capture the ciphertext at the end of the cycle.
	assign final_round = busy && (round_q == LAST_ROUND);

	assign done = done_q;

	// ----------------------------------------
	// state and counter
	// ----------------------------------------

	always_ff @(posedge eph1 or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= CTRL_IDLE;
			round_q <= '0;
			done_q  <= 1'b0;
		end else begin
			// done follows the last round by one edge, so it is a single pulse.
			done_q <= final_round;
			case (state_q)
				CTRL_IDLE: begin
					if (start) begin
						state_q <= CTRL_RUN;
						round_q <= 4'd1;
					end
				end
				CTRL_RUN: begin
					if (round_q == LAST_ROUND) begin
						state_q <= CTRL_IDLE;
					end else begin
						round_q <= round_q + 4'd1;
					end
				end
				default: state_q <= CTRL_IDLE;
			endcase
		end
	end

endmodule

//--- src/aes_key_sched.sv
// AES-128 key expansion computed one round key per clock.
// Holds the previous round key and the round constant, and derives the
// key for the current round combinationally through four S-boxes.

`timescale 1ns/10ps

`include "aes_config.svh"

module aes_key_sched import aes_pkg::*; (
	input  logic       eph1,
	input  logic       rst_n,
	input  logic       load,
	input  logic       step,
	input  aes_block_t cipher_key,
	output aes_block_t round_key
);

	// key of the previous round; right after load this is the cipher key.
	aes_block_t key_q;
	// round constant for the key being formed now.
	aes_byte_t  rcon_q;

	// last word of the previous key as a byte vector.
	// index 3 is the top row, index 0 the bottom row.
	logic [3:0][7:0] last_word;
	// the last word after RotWord and SubWord.
	logic [3:0][7:0] sub_word;
	// sub_word with the round constant folded into its top byte.
	aes_word_t       temp_word;

	// ----------------------------------------
	// next key, combinational
	// ----------------------------------------

	assign last_word = key_q.c3;

	// RotWord moves each byte up one row, with the top byte wrapping to
	// the bottom, so output row r reads input row (r + 1) mod 4.
	for (genvar r = 0; r < 4; r++) begin : g_subword
		aes_sbox sbox_inst (
			.in  (last_word[3-((r+1)%4)]),
			.out (sub_word[3-r])
		);
	end

	// the round constant only touches the top row.
	assign temp_word = sub_word ^ {rcon_q, 24'h000000};

	// each new word is the word above it in the old key plus the new word
	// just formed to its left, so the chain runs c0 to c3.
	assign round_key.c0 = key_q.c0 ^ temp_word;
	assign round_key.c1 = key_q.c1 ^ round_key.c0;
	assign round_key.c2 = key_q.c2 ^ round_key.c1;
	assign round_key.c3 = key_q.c3 ^ round_key.c2;

	// ----------------------------------------
	// key and round constant registers
	// ----------------------------------------

	// load takes the cipher key, and every round edge keeps the key just formed.
	always_ff @(posedge eph1) begin
		if (load) begin
			key_q <= cipher_key;
		end else if (step) begin
			key_q <= round_key;
		end
	end

	// the round constant starts at 01 and doubles in GF(2^8) every round.
	always_ff @(posedge eph1 or negedge rst_n) begin
		if (!rst_n) begin
			rcon_q <= 8'h01;
		end else if (load) begin
			rcon_q <= 8'h01;
		end else if (step) begin
			rcon_q <= {rcon_q[6:0], 1'b0} ^ (rcon_q[7] ? `AES_GF_POLY : 8'h00);
		end
	end

endmodule

//--- src/aes_pkg.sv
// Shared types for the AES-128 encryption core.
// Byte, word and block types of the cipher state, the control FSM
// state enum and the round index type.

package aes_pkg;

	// ----------------------------------------
	// state and key containers
	// ----------------------------------------

	// one byte of the state matrix or of a key word.
	typedef logic [7:0] aes_byte_t;

	// one column of the state, or one key word.
	// b0 is the top row and sits in the most significant byte, so a word
	// reads left to right the same way it is printed in FIPS-197.
	typedef struct packed {
		aes_byte_t b0;
		aes_byte_t b1;
		aes_byte_t b2;
		aes_byte_t b3;
	} aes_word_t;

	// a whole state block or round key of four columns.
	// column 0 is the most significant word, which makes a 128-bit hex
	// literal from the standard load straight into this type.
	typedef struct packed {
		aes_word_t c0;
		aes_word_t c1;
		aes_word_t c2;
		aes_word_t c3;
	} aes_block_t;

	// ----------------------------------------
	// control types
	// ----------------------------------------

	// the core is either waiting for a start strobe or running rounds.
	// only one block is ever in flight, so two states are enough.
	typedef enum logic {
		CTRL_IDLE = 1'b0,
		CTRL_RUN  = 1'b1
	} ctrl_state_t;

	// number of the round being computed, 1 through 10.
	// four bits leave headroom over the last round number.
	typedef logic [3:0] round_idx_t;

endpackage

//--- src/aes_round.sv
// One AES cipher round as pure combinational logic.
// SubBytes through sixteen S-boxes, ShiftRows, MixColumns and
// AddRoundKey, with MixColumns bypassed in the final round.

`timescale 1ns/10ps

`include "aes_config.svh"

module aes_round import aes_pkg::*; (
	input  aes_block_t state,
	input  aes_block_t round_key,
	input  logic       final_round,
	output aes_block_t next_state
);

	// one S-box per state byte.
	localparam int NBYTES = `AES_BLOCK_BITS / 8;

	// byte views of the block.
	// entry NBYTES-1 of a flat view is column 0, row 0, so the byte with
	// FIPS index k = 4*col + row lives at flat position NBYTES-1-k.
	logic [NBYTES-1:0][7:0] state_flat;
	logic [NBYTES-1:0][7:0] shift_flat;
	aes_byte_t              sub_bytes [NBYTES];
	aes_block_t             shift_blk;
	aes_block_t             mix_blk;

	// ----------------------------------------
	// GF(2^8) helpers
	// ----------------------------------------

	// multiply by x: shift left and fold the carry back with the field polynomial.
	function automatic aes_byte_t xtime(input aes_byte_t b);
		return {b[6:0], 1'b0} ^ (b[7] ? `AES_GF_POLY : 8'h00);
	endfunction

	// multiply by x + 1, which is the doubled value plus the original.
	function automatic aes_byte_t times3(input aes_byte_t b);
		return xtime(b) ^ b;
	endfunction

	// one column times the fixed circulant matrix {02 03 01 01}.
	// each output row rotates the coefficients one place to the right.
	function automatic aes_word_t mix_column(input aes_word_t w);
		aes_word_t m;
		m.b0 = xtime(w.b0) ^ times3(w.b1) ^ w.b2 ^ w.b3;
		m.b1 = w.b0 ^ xtime(w.b1) ^ times3(w.b2) ^ w.b3;
		m.b2 = w.b0 ^ w.b1 ^ xtime(w.b2) ^ times3(w.b3);
		m.b3 = times3(w.b0) ^ w.b1 ^ w.b2 ^ xtime(w.b3);
		return m;
	endfunction

	// ----------------------------------------
	// SubBytes
	// ----------------------------------------

	assign state_flat = state;

	// sub_bytes is kept in FIPS byte order to make ShiftRows below readable.
	for (genvar i = 0; i < NBYTES; i++) begin : g_sub
		aes_sbox sbox_inst (
			.in  (state_flat[NBYTES-1-i]),
			.out (sub_bytes[i])
		);
	end

	// ----------------------------------------
	// ShiftRows
	// ----------------------------------------

	// row r rotates left by r columns, so the byte landing in column c
	// comes from column (c + r) mod 4 of the same row.
	for (genvar c = 0; c < 4; c++) begin : g_col
		for (genvar r = 0; r < 4; r++) begin : g_row
			assign shift_flat[NBYTES-1-(4*c+r)] = sub_bytes[4*((c+r)%4)+r];
		end
	end

	assign shift_blk = shift_flat;

	// ----------------------------------------
	// MixColumns and AddRoundKey
	// ----------------------------------------

	// columns are mixed independently of each other.
	assign mix_blk.c0 = mix_column(shift_blk.c0);
	assign mix_blk.c1 = mix_column(shift_blk.c1);
	assign mix_blk.c2 = mix_column(shift_blk.c2);
	assign mix_blk.c3 = mix_column(shift_blk.c3);

	// the last round leaves MixColumns out and adds the key to the shifted bytes.
	assign next_state = (final_round ? shift_blk : mix_blk) ^ round_key;

endmodule

//--- src/aes_sbox.sv
// Rijndael forward S-box.
// A 256-entry constant table read combinationally with the input byte.

`timescale 1ns/10ps

module aes_sbox import aes_pkg::*; (
	input  aes_byte_t in,
	output aes_byte_t out
);

	// the table is listed in natural order, so entry n is S(n).
	// row boundaries of the FIPS-197 figure fall every second line.
	localparam aes_byte_t SBOX [256] = '{
		8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
		8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
		8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
		8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
		8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
		8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
		8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
		8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
		8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
		8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
		8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
		8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
		8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
		8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
		8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
		8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
		8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
		8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
		8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
		8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
		8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
		8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
		8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
		8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
		8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
		8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
		8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
		8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
		8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
		8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
		8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
		8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
	};

	// plain table read, no clock and no latency.
	assign out = SBOX[in];

endmodule

//--- tb/aes_assert.sv
// Concurrent protocol checks for the AES core, bound into aes_core.
// Done pulse width, busy window after a start, done placement and
// load exclusion while a block is in flight.

`timescale 1ns/10ps

`include "aes_config.svh"

module aes_assert (
	input logic eph1,
	input logic rst_n,
	input logic load,
	input logic busy,
	input logic done
);

	// number of failed assertions, read by the testbench at the end.
	int fail_count = 0;

	// done is a single-cycle pulse.
	done_single: assert property (@(posedge eph1) disable iff (!rst_n) done |=> !done)
		else begin $error("done was high for two cycles in a row"); fail_count++; end

	// an accepted start keeps busy high for every one of the ten rounds
	// and drops it in the cycle after that.
	busy_window: assert property (@(posedge eph1) disable iff (!rst_n)
		load |=> busy [*`AES_ROUNDS] ##1 !busy)
		else begin $error("busy window after a start is not ten cycles"); fail_count++; end

	// busy only falls once the full round count has passed since the start.
	busy_fall: assert property (@(posedge eph1) disable iff (!rst_n)
		$fell(busy) |-> $past(load, `AES_ROUNDS + 1))
		else begin $error("busy fell at the wrong time"); fail_count++; end

	// done sits exactly in the cycle after busy falls, and nowhere else.
	done_place: assert property (@(posedge eph1) disable iff (!rst_n) done == $fell(busy))
		else begin $error("done is not aligned with the fall of busy"); fail_count++; end

	// once a block is loaded, no further load happens until all its rounds are done.
	no_load_busy: assert property (@(posedge eph1) disable iff (!rst_n)
		load |=> !load [*`AES_ROUNDS])
		else begin $error("load occurred while busy"); fail_count++; end

endmodule

bind aes_core aes_assert aes_assert_inst (
	.eph1  (eph1),
	.rst_n (rst_n),
	.load  (load),
	.busy  (busy),
	.done  (done)
);

//--- tb/aes_tb.sv
// Testbench for the iterative AES-128 encryption core.
// Clock and reset, a table of FIPS-197 vectors applied in a loop,
// latency and busy checks, a start sent while busy, and the summary.

`timescale 1ns/10ps

module aes_tb
	import aes_pkg::*;
();

	// edges from an accepted start to done.
	localparam int LATENCY         = 10;
	localparam int TIMEOUT_CYCLES  = 40;
	localparam int MID_START_CYCLE = 5;
	localparam int IDLE_CYCLES     = 15;
	localparam int NUM_ROWS        = 5;

	// one stimulus row; mid_start asks for a second start while busy.
	typedef struct packed {
		aes_block_t key;
		aes_block_t plain;
		aes_block_t cipher;
		logic       mid_start;
	} vector_t;

	logic       eph1;
	logic       rst_n;
	logic       start;
	aes_block_t key;
	aes_block_t plain_text;
	logic       busy;
	logic       done;
	aes_block_t cipher_text;

	vector_t vectors [NUM_ROWS];
	string   row_name [NUM_ROWS];
	int      error_count;
	int      tests_passed;
	int      tests_failed;
	logic    timed_out;

	aes_core aes_core_inst (
		.eph1        (eph1),
		.rst_n       (rst_n),
		.start       (start),
		.key         (key),
		.plain_text  (plain_text),
		.busy        (busy),
		.done        (done),
		.cipher_text (cipher_text)
	);

	// 40 ns clock.
	initial begin
		eph1 = 1'b0;
		forever #20 eph1 = ~eph1;
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------

	// expected ciphertexts are the published FIPS-197 answers.
	// row 3 repeats the C.1 vector with a start sent in the middle of the run.
	task automatic fill_table();
		vectors[0] = '{128'h000102030405060708090a0b0c0d0e0f,
			128'h00112233445566778899aabbccddeeff, 128'h69c4e0d86a7b0430d8cdb78070b4c55a, 1'b0};
		vectors[1] = '{128'h2b7e151628aed2a6abf7158809cf4f3c,
			128'h3243f6a8885a308d313198a2e0370734, 128'h3925841d02dc09fbdc118597196a0b32, 1'b0};
		vectors[2] = '{128'h0, 128'h0, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e, 1'b0};
		vectors[3] = '{128'h000102030405060708090a0b0c0d0e0f,
			128'h00112233445566778899aabbccddeeff, 128'h69c4e0d86a7b0430d8cdb78070b4c55a, 1'b1};
		vectors[4] = vectors[1];
		row_name[0] = "fips197_c1";
		row_name[1] = "fips197_b";
		row_name[2] = "zero_key";
		row_name[3] = "start_busy";
		row_name[4] = "back_to_back";
	endtask

	task automatic compare(input string what, input logic [127:0] expected,
		input logic [127:0] actual);
		if (expected !== actual) begin
			$display("Mismatch in %s: expected %0h, actual %0h", what, expected, actual);
			error_count++;
		end
	endtask

	function automatic aes_block_t random_block();
		return {$urandom(), $urandom(), $urandom(), $urandom()};
	endfunction

	// one line per finished test.
	task automatic finish_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			$display("test %s: ok", name);
			tests_passed++;
		end else begin
			$display("test %s: %0d errors", name, error_count - errors_before);
			tests_failed++;
		end
	endtask

	// ----------------------------------------
	// tests
	// ----------------------------------------

	task automatic check_reset();
		int errors_before;
		errors_before = error_count;
		compare("reset busy", 128'(1'b0), 128'(busy));
		compare("reset done", 128'(1'b0), 128'(done));
		compare("reset cipher_text", 128'h0, cipher_text);
		finish_test("reset", errors_before);
	endtask

	// drives one row and waits for done. It returns in the done cycle, so
	// the next row's start lands in that cycle too.
	task automatic run_row(input int idx);
		vector_t row;
		int      cycles;
		int      errors_before;
		logic    finished;
		row = vectors[idx];
		errors_before = error_count;
		key = row.key;
		plain_text = row.plain;
		start = 1'b1;
		@(posedge eph1);
		#2;
		start = 1'b0;
		// the first round is already running in this cycle.
		compare({row_name[idx], " busy after start"}, 128'(1'b1), 128'(busy));
		cycles = 0;
		finished = 1'b0;
		while (!finished && cycles < TIMEOUT_CYCLES) begin
			@(posedge eph1);
			#2;
			cycles++;
			if (done) begin
				finished = 1'b1;
			end else begin
				if (!busy) begin
					$display("busy was low in cycle %0d of test %s", cycles, row_name[idx]);
					error_count++;
				end
				// the extra start carries fresh random data that must be ignored.
				if (row.mid_start && cycles == MID_START_CYCLE) begin
					start = 1'b1;
					key = random_block();
					plain_text = random_block();
				end else begin
					start = 1'b0;
				end
			end
		end
		if (!finished) begin
			$display("done did not rise within %0d cycles in test %s", TIMEOUT_CYCLES,
				row_name[idx]);
			error_count++;
			timed_out = 1'b1;
		end else begin
			compare({row_name[idx], " latency"}, 128'(LATENCY), 128'(cycles));
			compare({row_name[idx], " busy at done"}, 128'(1'b0), 128'(busy));
			compare({row_name[idx], " ciphertext"}, row.cipher, cipher_text);
		end
		finish_test(row_name[idx], errors_before);
	endtask

	// after the last block no further done may appear.
	task automatic check_idle();
		int errors_before;
		int done_count;
		errors_before = error_count;
		done_count = 0;
		start = 1'b0;
		for (int i = 0; i < IDLE_CYCLES; i++) begin
			@(posedge eph1);
			#2;
			if (done) begin
				done_count++;
			end
			compare("idle busy", 128'(1'b0), 128'(busy));
		end
		compare("idle done count", 128'(0), 128'(done_count));
		finish_test("idle_after", errors_before);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------

	initial begin
		int assert_fails;
		rst_n = 1'b0;
		start = 1'b0;
		key = '0;
		plain_text = '0;
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		void'($urandom(32'h2897_e848));
		fill_table();
		repeat (4) @(posedge eph1);
		#2;
		rst_n = 1'b1;
		check_reset();
		for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
			run_row(i);
		end
		if (!timed_out) begin
			check_idle();
		end
		assert_fails = aes_core_inst.aes_assert_inst.fail_count;
		if (assert_fails != 0) begin
			$display("%0d protocol assertions failed", assert_fails);
			error_count += assert_fails;
		end
		$display("tests passed: %0d, tests failed: %0d, errors: %0d", tests_passed,
			tests_failed, error_count);
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
